// File: rtl/tlu_pkg.sv
// trigger controller package: widths, payload types, register addresses, constants
package tlu_pkg;

    localparam int TRIGGER_WIDTH  = 8;  // trigger and veto channels
    localparam int BUS_ADDR_WIDTH = 16;
    localparam int SYNC_STAGES    = 3;
    localparam int FIFO_DEPTH     = 8;  // power of two

    typedef logic [TRIGGER_WIDTH-1:0] trig_vec_t;
    typedef logic [7:0]               bus_byte_t;
    typedef logic [31:0]              trigger_word_t;

    localparam bus_byte_t VERSION = 8'd10;

    // register map of the byte bus
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_CTRL = 16'd0;  // a write gives the soft reset
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_CONF = 16'd1;  // bit 0 trigger enable
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_CNT0 = 16'd4;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_CNT1 = 16'd5;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_CNT2 = 16'd6;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_CNT3 = 16'd7;  // write loads the counter
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_LOST = 16'd8;  // read only
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_SEL  = 16'd9;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_VETO = 16'd10;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_INV  = 16'd11;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_MAX0 = 16'd12;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_MAX1 = 16'd13;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_MAX2 = 16'd14;
    localparam logic [BUS_ADDR_WIDTH-1:0] ADDR_MAX3 = 16'd15;

endpackage

// File: rtl/trigger_cfg_if.sv
// configuration and counter interface between register bank and trigger path
`timescale 1ns/1ps

interface trigger_cfg_if;

    tlu_pkg::trig_vec_t     trigger_select;
    tlu_pkg::trig_vec_t     trigger_invert;
    tlu_pkg::trig_vec_t     veto_select;
    logic                   trigger_enable;
    tlu_pkg::trigger_word_t counter_max;        // 0 means no limit
    logic                   counter_set;        // one-cycle load strobe
    tlu_pkg::trigger_word_t counter_set_value;
    tlu_pkg::trigger_word_t trigger_count;      // live counter from the acceptor

    modport bank (
        output trigger_select, trigger_invert, veto_select, trigger_enable,
        output counter_max, counter_set, counter_set_value,
        input  trigger_count
    );

    modport conditioner (input trigger_select, trigger_invert, veto_select);

    modport acceptor (
        input  trigger_enable, counter_max, counter_set, counter_set_value,
        output trigger_count
    );

endinterface

// File: rtl/trigger_register_bank.sv
// register bank: bus decode, configuration bytes, counter snapshot, soft reset
`timescale 1ns/1ps

module trigger_register_bank (
    input  logic                               BUS_CLK,
    input  logic                               RST,
    input  logic [tlu_pkg::BUS_ADDR_WIDTH-1:0] bus_add,
    input  tlu_pkg::bus_byte_t                 bus_data_in,
    input  logic                               bus_rd,
    input  logic                               bus_wr,
    input  tlu_pkg::bus_byte_t                 lost_count,
    output tlu_pkg::bus_byte_t                 bus_data_out,
    output logic                               soft_rst,
    trigger_cfg_if.bank                        cfg
);

    tlu_pkg::bus_byte_t     conf_reg;
    tlu_pkg::trig_vec_t     sel_reg;
    tlu_pkg::trig_vec_t     veto_reg;
    tlu_pkg::trig_vec_t     inv_reg;
    tlu_pkg::bus_byte_t     cnt_reg [0:2];      // lower bytes of the load value
    tlu_pkg::bus_byte_t     max_reg [0:3];
    tlu_pkg::trigger_word_t count_snap;         // taken on a read of CNT0
    logic                   ctrl_wr;
    logic                   cnt_load;

    assign ctrl_wr  = bus_wr && (bus_add == tlu_pkg::ADDR_CTRL);
    assign cnt_load = bus_wr && (bus_add == tlu_pkg::ADDR_CNT3);

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            conf_reg <= '0;
            sel_reg  <= '0;
            veto_reg <= '0;
            inv_reg  <= '0;
            for (int i = 0; i < 3; i++)
                cnt_reg[i] <= '0;
            for (int i = 0; i < 4; i++)
                max_reg[i] <= '0;
        end
        else if (bus_wr)
        begin
            case (bus_add)
                tlu_pkg::ADDR_CONF: conf_reg <= bus_data_in;
                tlu_pkg::ADDR_SEL:  sel_reg  <= bus_data_in;
                tlu_pkg::ADDR_VETO: veto_reg <= bus_data_in;
                tlu_pkg::ADDR_INV:  inv_reg  <= bus_data_in;
                tlu_pkg::ADDR_CNT0, tlu_pkg::ADDR_CNT1, tlu_pkg::ADDR_CNT2:
                    cnt_reg[bus_add[1:0]] <= bus_data_in;
                tlu_pkg::ADDR_MAX0, tlu_pkg::ADDR_MAX1, tlu_pkg::ADDR_MAX2, tlu_pkg::ADDR_MAX3:
                    max_reg[bus_add[1:0]] <= bus_data_in;
                default: ;
            endcase
        end
    end

    // soft reset and counter load leave here one cycle after the write
    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            soft_rst        <= 1'b0;
            cfg.counter_set <= 1'b0;
        end
        else
        begin
            soft_rst        <= ctrl_wr;
            cfg.counter_set <= cnt_load;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (cnt_load)
            cfg.counter_set_value <= {bus_data_in, cnt_reg[2], cnt_reg[1], cnt_reg[0]};
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            bus_data_out <= '0;
            count_snap   <= '0;
        end
        else if (bus_rd)
        begin
            case (bus_add)
                tlu_pkg::ADDR_CTRL: bus_data_out <= tlu_pkg::VERSION;
                tlu_pkg::ADDR_CONF: bus_data_out <= conf_reg;
                tlu_pkg::ADDR_CNT0:
                begin
                    bus_data_out <= cfg.trigger_count[7:0];   // live low byte
                    count_snap   <= cfg.trigger_count;
                end
                tlu_pkg::ADDR_CNT1: bus_data_out <= count_snap[15:8];
                tlu_pkg::ADDR_CNT2: bus_data_out <= count_snap[23:16];
                tlu_pkg::ADDR_CNT3: bus_data_out <= count_snap[31:24];
                tlu_pkg::ADDR_LOST: bus_data_out <= lost_count;
                tlu_pkg::ADDR_SEL:  bus_data_out <= sel_reg;
                tlu_pkg::ADDR_VETO: bus_data_out <= veto_reg;
                tlu_pkg::ADDR_INV:  bus_data_out <= inv_reg;
                tlu_pkg::ADDR_MAX0, tlu_pkg::ADDR_MAX1, tlu_pkg::ADDR_MAX2, tlu_pkg::ADDR_MAX3:
                    bus_data_out <= max_reg[bus_add[1:0]];
                default:            bus_data_out <= '0;
            endcase
        end
    end

    assign cfg.trigger_select = sel_reg;
    assign cfg.trigger_invert = inv_reg;
    assign cfg.veto_select    = veto_reg;
    assign cfg.trigger_enable = conf_reg[0];
    assign cfg.counter_max    = {max_reg[3], max_reg[2], max_reg[1], max_reg[0]};

endmodule

// File: rtl/trigger_input_conditioner.sv
// input conditioner: invert, select and veto reduction, synchronizers, edge detect
`timescale 1ns/1ps

module trigger_input_conditioner (
    input  logic               BUS_CLK,
    input  logic               RST,
    input  tlu_pkg::trig_vec_t trigger,
    input  tlu_pkg::trig_vec_t trigger_veto,
    output logic               trigger_edge,
    output logic               veto,
    trigger_cfg_if.conditioner cfg
);

    logic                            trigger_or;
    logic                            veto_or;
    logic [tlu_pkg::SYNC_STAGES-1:0] trig_sync;
    logic [tlu_pkg::SYNC_STAGES-1:0] veto_sync;
    logic                            trig_last;

    // a channel is active when selected and high after inversion
    assign trigger_or = |((trigger ^ cfg.trigger_invert) & cfg.trigger_select);
    assign veto_or    = |(trigger_veto & cfg.veto_select);

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trig_sync <= '0;
            veto_sync <= '0;
            trig_last <= 1'b0;
        end
        else
        begin
            trig_sync <= {trig_sync[tlu_pkg::SYNC_STAGES-2:0], trigger_or};
            veto_sync <= {veto_sync[tlu_pkg::SYNC_STAGES-2:0], veto_or};
            trig_last <= trig_sync[tlu_pkg::SYNC_STAGES-1];
        end
    end

    assign trigger_edge = trig_sync[tlu_pkg::SYNC_STAGES-1] & ~trig_last;  // rising edge
    assign veto         = veto_sync[tlu_pkg::SYNC_STAGES-1];

endmodule

// File: rtl/trigger_acceptor.sv
// trigger acceptor: enable and limit, veto, acknowledge wait, loadable trigger counter
`timescale 1ns/1ps

module trigger_acceptor (
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  logic                   trigger_edge,
    input  logic                   veto,
    input  logic                   ext_trigger_enable,
    input  logic                   trigger_acknowledge,
    output logic                   trigger_accepted_flag,
    output logic                   trigger_enabled,
    output logic                   word_write,
    output tlu_pkg::trigger_word_t trigger_word,
    trigger_cfg_if.acceptor        cfg
);

    tlu_pkg::trigger_word_t count;
    logic                   limit_reached;
    logic                   ack_pending;
    logic                   accept;

    // zero max means counting without limit
    assign limit_reached   = (cfg.counter_max != '0) && (count >= cfg.counter_max);
    assign trigger_enabled = cfg.trigger_enable && !limit_reached;

    assign accept = trigger_edge && !veto && trigger_enabled && !ack_pending;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            ack_pending <= 1'b0;
        else if (accept && ext_trigger_enable)
            ack_pending <= 1'b1;               // hold off until acknowledged
        else if (trigger_acknowledge || !ext_trigger_enable)
            ack_pending <= 1'b0;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            count <= '0;
        else if (cfg.counter_set)
            count <= cfg.counter_set_value;
        else if (accept)
            count <= count + 1'b1;             // counts even when the FIFO drops the word
    end

    assign trigger_accepted_flag = accept;
    assign word_write            = accept;
    assign trigger_word          = count;      // value before the increment
    assign cfg.trigger_count     = count;

endmodule

// File: rtl/trigger_word_fifo.sv
// trigger word FIFO: first-word fall-through circular buffer, lost-data counter
`timescale 1ns/1ps

module trigger_word_fifo (
    input  logic                   BUS_CLK,
    input  logic                   RST,
    input  logic                   word_write,
    input  tlu_pkg::trigger_word_t trigger_word,
    input  logic                   fifo_read,
    output logic                   fifo_empty,
    output tlu_pkg::trigger_word_t fifo_data,
    output tlu_pkg::bus_byte_t     lost_count
);

    tlu_pkg::trigger_word_t                 mem [tlu_pkg::FIFO_DEPTH];
    logic [$clog2(tlu_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(tlu_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(tlu_pkg::FIFO_DEPTH):0]   fill;
    logic                                   full;
    logic                                   push;
    logic                                   pop;

    assign full       = fill[$clog2(tlu_pkg::FIFO_DEPTH)];  // fill == depth
    assign fifo_empty = (fill == '0);
    assign push       = word_write && !full;
    assign pop        = fifo_read && !fifo_empty;

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr] <= trigger_word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            lost_count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;       // pointers wrap at the depth
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
            if (word_write && full && lost_count != '1)
                lost_count <= lost_count + 1'b1;   // saturates at 255
        end
    end

    assign fifo_data = mem[rd_ptr];            // head shows while not empty

endmodule

// File: rtl/tlu_trigger_top.sv
// TLU trigger top level: register bank, input conditioner, acceptor, output FIFO
`timescale 1ns/1ps

module tlu_trigger_top (
    input  logic                               BUS_CLK,
    input  logic                               RST,
    input  logic [tlu_pkg::BUS_ADDR_WIDTH-1:0] bus_add,
    input  tlu_pkg::bus_byte_t                 bus_data_in,
    input  logic                               bus_rd,
    input  logic                               bus_wr,
    output tlu_pkg::bus_byte_t                 bus_data_out,
    input  tlu_pkg::trig_vec_t                 trigger,
    input  tlu_pkg::trig_vec_t                 trigger_veto,
    input  logic                               ext_trigger_enable,
    input  logic                               trigger_acknowledge,
    output logic                               trigger_accepted_flag,
    output logic                               trigger_enabled,
    output tlu_pkg::trig_vec_t                 trigger_selected,
    input  logic                               fifo_read,
    output logic                               fifo_empty,
    output tlu_pkg::trigger_word_t             fifo_data
);

    logic                   soft_rst;
    logic                   rst;
    logic                   trigger_edge;
    logic                   veto;
    logic                   word_write;
    tlu_pkg::trigger_word_t trigger_word;
    tlu_pkg::bus_byte_t     lost_count;

    trigger_cfg_if cfg ();

    assign rst              = RST | soft_rst;  // soft reset acts like the bus reset
    assign trigger_selected = cfg.trigger_select;

    trigger_register_bank u_bank (
        .BUS_CLK      (BUS_CLK),
        .RST          (rst),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .lost_count   (lost_count),
        .bus_data_out (bus_data_out),
        .soft_rst     (soft_rst),
        .cfg          (cfg)
    );

    trigger_input_conditioner u_cond (
        .BUS_CLK      (BUS_CLK),
        .RST          (rst),
        .trigger      (trigger),
        .trigger_veto (trigger_veto),
        .trigger_edge (trigger_edge),
        .veto         (veto),
        .cfg          (cfg)
    );

    trigger_acceptor u_acc (
        .BUS_CLK               (BUS_CLK),
        .RST                   (rst),
        .trigger_edge          (trigger_edge),
        .veto                  (veto),
        .ext_trigger_enable    (ext_trigger_enable),
        .trigger_acknowledge   (trigger_acknowledge),
        .trigger_accepted_flag (trigger_accepted_flag),
        .trigger_enabled       (trigger_enabled),
        .word_write            (word_write),
        .trigger_word          (trigger_word),
        .cfg                   (cfg)
    );

    trigger_word_fifo u_fifo (
        .BUS_CLK      (BUS_CLK),
        .RST          (rst),
        .word_write   (word_write),
        .trigger_word (trigger_word),
        .fifo_read    (fifo_read),
        .fifo_empty   (fifo_empty),
        .fifo_data    (fifo_data),
        .lost_count   (lost_count)
    );

endmodule

// File: test/tlu_trigger_sva.sv
// bound assertions on the trigger acceptor: one-cycle accept, veto and enable gating, word count
`timescale 1ns/1ps

module tlu_trigger_sva (
    input logic                   BUS_CLK,
    input logic                   RST,
    input logic                   trigger_accepted_flag,
    input logic                   veto,
    input logic                   trigger_enabled,
    input logic                   word_write,
    input tlu_pkg::trigger_word_t trigger_word,
    input tlu_pkg::trigger_word_t count,
    input logic                   counter_set
);

    accept_one_cycle: assert property (@(posedge BUS_CLK) disable iff (RST)
        trigger_accepted_flag |=> !trigger_accepted_flag)
        else $error("accepted flag high for more than one cycle");

    // blocked triggers leave the counter alone
    accept_gated: assert property (@(posedge BUS_CLK) disable iff (RST)
        ((veto || !trigger_enabled) && !counter_set) |=> (count == $past(count)))
        else $error("trigger counted under veto or while disabled");

    write_counts: assert property (@(posedge BUS_CLK) disable iff (RST)
        (word_write && !counter_set) |=> (count == $past(trigger_word) + 1))
        else $error("written trigger word is not the count before the increment");

endmodule

bind trigger_acceptor tlu_trigger_sva u_sva (
    .BUS_CLK               (BUS_CLK),
    .RST                   (RST),
    .trigger_accepted_flag (trigger_accepted_flag),
    .veto                  (veto),
    .trigger_enabled       (trigger_enabled),
    .word_write            (word_write),
    .trigger_word          (trigger_word),
    .count                 (count),
    .counter_set           (cfg.counter_set)
);

// File: test/tb_tlu_trigger.sv
// testbench for the TLU trigger controller: clock, reset, bus and trigger tasks, directed tests
`timescale 1ns/1ps

module tb_tlu_trigger;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int WATCHDOG_CYCLES = 100000;

    logic                               BUS_CLK;
    logic                               RST;
    logic [tlu_pkg::BUS_ADDR_WIDTH-1:0] bus_add;
    tlu_pkg::bus_byte_t                 bus_data_in;
    logic                               bus_rd;
    logic                               bus_wr;
    tlu_pkg::bus_byte_t                 bus_data_out;
    tlu_pkg::trig_vec_t                 trigger;
    tlu_pkg::trig_vec_t                 trigger_veto;
    logic                               ext_trigger_enable;
    logic                               trigger_acknowledge;
    logic                               trigger_accepted_flag;
    logic                               trigger_enabled;
    tlu_pkg::trig_vec_t                 trigger_selected;
    logic                               fifo_read;
    logic                               fifo_empty;
    tlu_pkg::trigger_word_t             fifo_data;

    integer seed;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     accept_count = 0;   // accepts seen since time 0

    tlu_trigger_top UUT (.*);

    initial
    begin
        BUS_CLK = 1'b0;
        forever #50 BUS_CLK = ~BUS_CLK;
    end

    // flag is one cycle long, so the falling edge sees it once
    always @(negedge BUS_CLK)
    begin
        if (trigger_accepted_flag)
            accept_count++;
    end

    task automatic check_value(input string test_name, input longint expected,
                               input longint actual);
        assert (expected == actual)
        else
        begin
            $display("FAIL %s: expected %0d, actual %0d", test_name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string test_name, input bit cond, input string what);
        assert (cond)
        else
        begin
            $display("%s: %s", test_name, what);
            errors++;
        end
    endtask

    task automatic finish_test(input string test_name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("test %s: ok", test_name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_before);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input tlu_pkg::bus_byte_t data);
        @(posedge BUS_CLK);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr      <= 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output tlu_pkg::bus_byte_t data);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd  <= 1'b0;
        @(negedge BUS_CLK);
        data = bus_data_out;    // registered on the edge after bus_rd
    endtask

    // CNT0 goes first since it takes the snapshot for the upper bytes
    task automatic read_counter(output tlu_pkg::trigger_word_t value);
        tlu_pkg::bus_byte_t data;
        for (int i = 0; i < 4; i++)
        begin
            bus_read(tlu_pkg::ADDR_CNT0 + 16'(i), data);
            value[8*i +: 8] = data;
        end
    endtask

    task automatic soft_reset();
        @(posedge BUS_CLK);
        trigger             <= '0;
        trigger_veto        <= '0;
        ext_trigger_enable  <= 1'b0;
        trigger_acknowledge <= 1'b0;
        fifo_read           <= 1'b0;
        bus_write(tlu_pkg::ADDR_CTRL, 8'h00);
        repeat (6) @(posedge BUS_CLK);  // inputs at rest through the synchronizer
    endtask

    // toggles the given channels away from rest and back
    task automatic pulse_trigger(input tlu_pkg::trig_vec_t bits);
        @(posedge BUS_CLK);
        trigger <= trigger ^ bits;
        repeat (4) @(posedge BUS_CLK);
        trigger <= trigger ^ bits;
        repeat (5) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
    endtask

    task automatic wait_accepts(input string test_name, input int target);
        int cycles;
        cycles = 0;
        while (accept_count < target && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge BUS_CLK);
            cycles++;
        end
        check_flag(test_name, accept_count >= target,
                   "timed out waiting for trigger_accepted_flag");
    endtask

    task automatic pop_word(input string test_name, input tlu_pkg::trigger_word_t expected);
        int cycles;
        cycles = 0;
        @(negedge BUS_CLK);
        while (fifo_empty && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge BUS_CLK);
            cycles++;
        end
        check_flag(test_name, !fifo_empty, "timed out waiting for a FIFO word");
        if (!fifo_empty)
            check_value(test_name, expected, fifo_data);
        @(posedge BUS_CLK);
        fifo_read <= 1'b1;
        @(posedge BUS_CLK);
        fifo_read <= 1'b0;
    endtask

    task automatic test_registers();
        tlu_pkg::bus_byte_t values [7];
        tlu_pkg::bus_byte_t data;
        int                 errors_before;
        errors_before = errors;
        // SEL, VETO, INV and MAX0..MAX3 sit at 9 to 15
        for (int i = 0; i < 7; i++)
        begin
            values[i] = 8'($random(seed));
            bus_write(tlu_pkg::ADDR_SEL + 16'(i), values[i]);
        end
        for (int i = 0; i < 7; i++)
        begin
            bus_read(tlu_pkg::ADDR_SEL + 16'(i), data);
            check_value("registers", values[i], data);
        end
        bus_read(tlu_pkg::ADDR_CTRL, data);
        check_value("registers", 10, data);     // version
        check_value("registers", values[0], trigger_selected);
        finish_test("registers", errors_before);
    endtask

    task automatic test_select_invert();
        int errors_before;
        int start;
        errors_before = errors;
        soft_reset();
        bus_write(tlu_pkg::ADDR_SEL, 8'h04);
        bus_write(tlu_pkg::ADDR_CONF, 8'h01);
        start = accept_count;
        pulse_trigger(8'h04);
        wait_accepts("select_invert", start + 1);
        pop_word("select_invert", 0);
        pulse_trigger(8'h20);                   // channel 5 not selected
        check_value("select_invert", start + 1, accept_count);
        check_flag("select_invert", fifo_empty, "unselected channel produced a FIFO word");
        // channel 2 settles high at rest while the path is disabled
        bus_write(tlu_pkg::ADDR_CONF, 8'h00);
        @(posedge BUS_CLK);
        trigger <= 8'h04;
        bus_write(tlu_pkg::ADDR_INV, 8'h04);
        repeat (6) @(posedge BUS_CLK);
        bus_write(tlu_pkg::ADDR_CONF, 8'h01);
        pulse_trigger(8'h04);                   // low pulse
        wait_accepts("select_invert", start + 2);
        pop_word("select_invert", 1);
        finish_test("select_invert", errors_before);
    endtask

    task automatic test_veto();
        tlu_pkg::trigger_word_t count;
        int                     errors_before;
        int                     start;
        errors_before = errors;
        soft_reset();
        bus_write(tlu_pkg::ADDR_SEL, 8'h04);
        bus_write(tlu_pkg::ADDR_VETO, 8'h01);
        bus_write(tlu_pkg::ADDR_CONF, 8'h01);
        @(posedge BUS_CLK);
        trigger_veto <= 8'h01;
        repeat (5) @(posedge BUS_CLK);
        start = accept_count;
        pulse_trigger(8'h04);
        check_value("veto", start, accept_count);
        read_counter(count);
        check_value("veto", 0, count);
        check_flag("veto", fifo_empty, "vetoed trigger produced a FIFO word");
        @(posedge BUS_CLK);
        trigger_veto <= '0;
        finish_test("veto", errors_before);
    endtask

    task automatic test_counter_limit();
        tlu_pkg::trigger_word_t count;
        int                     errors_before;
        int                     start;
        errors_before = errors;
        soft_reset();
        bus_write(tlu_pkg::ADDR_SEL, 8'h04);
        bus_write(tlu_pkg::ADDR_CONF, 8'h01);
        bus_write(tlu_pkg::ADDR_MAX0, 8'd7);
        bus_write(tlu_pkg::ADDR_CNT0, 8'd5);
        bus_write(tlu_pkg::ADDR_CNT1, 8'd0);
        bus_write(tlu_pkg::ADDR_CNT2, 8'd0);
        bus_write(tlu_pkg::ADDR_CNT3, 8'd0);  // load strobe
        repeat (2) @(posedge BUS_CLK);
        start = accept_count;
        repeat (4) pulse_trigger(8'h04);
        wait_accepts("counter_limit", start + 2);
        check_value("counter_limit", start + 2, accept_count);
        check_flag("counter_limit", !trigger_enabled,
                   "trigger_enabled stayed high at the counter limit");
        read_counter(count);
        check_value("counter_limit", 7, count);
        pop_word("counter_limit", 5);
        pop_word("counter_limit", 6);
        @(negedge BUS_CLK);
        check_flag("counter_limit", fifo_empty, "extra FIFO word after the limit");
        finish_test("counter_limit", errors_before);
    endtask

    task automatic test_ext_acknowledge();
        int errors_before;
        int start;
        errors_before = errors;
        soft_reset();
        bus_write(tlu_pkg::ADDR_SEL, 8'h04);
        bus_write(tlu_pkg::ADDR_CONF, 8'h01);
        @(posedge BUS_CLK);
        ext_trigger_enable <= 1'b1;
        start = accept_count;
        pulse_trigger(8'h04);
        wait_accepts("ext_acknowledge", start + 1);
        pulse_trigger(8'h04);                   // acknowledge still pending
        check_value("ext_acknowledge", start + 1, accept_count);
        @(posedge BUS_CLK);
        trigger_acknowledge <= 1'b1;
        @(posedge BUS_CLK);
        trigger_acknowledge <= 1'b0;
        pulse_trigger(8'h04);
        wait_accepts("ext_acknowledge", start + 2);
        pop_word("ext_acknowledge", 0);
        pop_word("ext_acknowledge", 1);
        @(posedge BUS_CLK);
        ext_trigger_enable <= 1'b0;
        finish_test("ext_acknowledge", errors_before);
    endtask

    task automatic test_overflow();
        tlu_pkg::trigger_word_t count;
        tlu_pkg::bus_byte_t     data;
        int                     errors_before;
        int                     start;
        errors_before = errors;
        soft_reset();
        bus_write(tlu_pkg::ADDR_SEL, 8'h04);
        bus_write(tlu_pkg::ADDR_CONF, 8'h01);
        start = accept_count;
        repeat (10) pulse_trigger(8'h04);
        wait_accepts("overflow", start + 10);
        bus_read(tlu_pkg::ADDR_LOST, data);
        check_value("overflow", 2, data);
        read_counter(count);
        check_value("overflow", 10, count);
        for (int i = 0; i < 8; i++)
            pop_word("overflow", i);
        @(negedge BUS_CLK);
        check_flag("overflow", fifo_empty, "FIFO not empty after eight reads");
        finish_test("overflow", errors_before);
    endtask

    initial
    begin
        seed                = 32'hbfad_a3f9;
        RST                 = 1'b1;
        bus_add             = '0;
        bus_data_in         = '0;
        bus_rd              = 1'b0;
        bus_wr              = 1'b0;
        trigger             = '0;
        trigger_veto        = '0;
        ext_trigger_enable  = 1'b0;
        trigger_acknowledge = 1'b0;
        fifo_read           = 1'b0;
        repeat (8) @(posedge BUS_CLK);
        RST <= 1'b0;
        test_registers();
        test_select_invert();
        test_veto();
        test_counter_limit();
        test_ext_acknowledge();
        test_overflow();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge BUS_CLK);
        $display("simulation ran past the watchdog limit");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: sources.f
rtl/tlu_pkg.sv
rtl/trigger_cfg_if.sv
rtl/trigger_register_bank.sv
rtl/trigger_input_conditioner.sv
rtl/trigger_acceptor.sv
rtl/trigger_word_fifo.sv
rtl/tlu_trigger_top.sv
test/tlu_trigger_sva.sv
test/tb_tlu_trigger.sv

// File: run.sh
#!/bin/sh
# compile and run the trigger controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_tlu_trigger -Mdir obj_dir -o sim_tb_tlu_trigger
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_tlu_trigger)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF "All tests passed!"; then
    exit 0
fi
exit 1
